// File: src/chip_io_pkg.sv
//////////////////////////////////////////////////
// chip io shell package
// pad layouts, power sequence thresholds and shared types
//////////////////////////////////////////////////

`default_nettype none

package chip_io_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////

  localparam int unsigned GPIO_W      = 32;
  localparam int unsigned N_GENERIC   = 14;
  localparam int unsigned N_SW_STRAP  = 3;
  localparam int unsigned N_TAP_STRAP = 2;

  // depth of the pad input synchronizer
  localparam int unsigned SYNC_STAGES = 2;

  //////////////////////////////////////////////////
  // fake supply ramp
  //////////////////////////////////////////////////

  localparam int unsigned RAMP_W = 4;

  // supply low, high, low, then high for good
  localparam logic [RAMP_W-1:0] RAMP_ON1 = 4'd4;
  localparam logic [RAMP_W-1:0] RAMP_OFF = 4'd8;
  localparam logic [RAMP_W-1:0] RAMP_ON2 = 4'd12;

  // longer than the first high window, so that one is filtered out
  localparam int unsigned POR_STABLE_CYCLES = 6;
  localparam int unsigned STABLE_W          = $clog2(POR_STABLE_CYCLES + 1);

  //////////////////////////////////////////////////
  // pad side gpio word
  //////////////////////////////////////////////////

  typedef struct packed {
    logic                     rsvd_31;
    logic                     tap_strap1;
    logic [1:0]               rsvd_29_28;
    logic                     tap_strap0;
    logic [1:0]               rsvd_26_25;
    logic [N_SW_STRAP-1:0]    sw_strap;
    logic [7:0]               rsvd_21_14;
    logic [N_GENERIC/2-1:0]   generic_hi;
    logic [N_GENERIC/2-1:0]   generic_lo;
  } gpio_fields_t;

  // one pad word, seen as raw bits or as its fields
  typedef union packed {
    logic [GPIO_W-1:0] raw;
    gpio_fields_t      f;
  } gpio_word_u;

  //////////////////////////////////////////////////
  // core side pad vector
  //////////////////////////////////////////////////

  // uart is rx towards the core and tx towards the pads
  // usb_sense is input only
  typedef struct packed {
    logic [N_GENERIC-1:0]   generic;
    logic [N_SW_STRAP-1:0]  sw_strap;
    logic [N_TAP_STRAP-1:0] tap_strap;
    logic                   uart;
    logic                   usb_sense;
  } mio_pads_t;

  typedef struct packed {
    logic [N_SW_STRAP-1:0]  sw;
    logic [N_TAP_STRAP-1:0] tap;
  } straps_t;

  typedef struct packed {
    logic vcc_supp;
    logic por_ok;
  } pwr_status_t;

endpackage : chip_io_pkg

`default_nettype wire

// File: src/pad_map.sv
//////////////////////////////////////////////////
// pad map
// syncs pad inputs into the core vector and maps core outputs onto pads
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module pad_map (
  input  logic                    clk_aon,
  input  logic                    rst_i,

  // pad side
  input  chip_io_pkg::gpio_word_u gpio_i,
  input  logic                    uart_rx_i,
  input  logic                    usb_sense_i,
  output chip_io_pkg::gpio_word_u gpio_o,
  output chip_io_pkg::gpio_word_u gpio_en_o,
  output logic                    uart_tx_o,
  output logic                    uart_tx_en_o,

  // core side
  input  chip_io_pkg::mio_pads_t  core_out_i,
  input  chip_io_pkg::mio_pads_t  core_oe_i,
  output chip_io_pkg::mio_pads_t  core_pads_o,
  output chip_io_pkg::straps_t    sync_straps_o
);

  import chip_io_pkg::*;

  mio_pads_t pad_vec;
  mio_pads_t sync_q [SYNC_STAGES];

  // core vector onto the gpio word with reserved bits at zero
  function automatic gpio_word_u map_to_gpio(input mio_pads_t pads);
    gpio_word_u word;
    word.raw          = '0;
    word.f.generic_lo = pads.generic[N_GENERIC/2-1:0];
    word.f.generic_hi = pads.generic[N_GENERIC-1:N_GENERIC/2];
    word.f.sw_strap   = pads.sw_strap;
    word.f.tap_strap0 = pads.tap_strap[0];
    word.f.tap_strap1 = pads.tap_strap[1];
    return word;
  endfunction

  //////////////////////////////////////////////////
  // pads to core
  //////////////////////////////////////////////////

  // decode through the field view so reserved pad bits drop out
  always_comb begin
    pad_vec.generic   = {gpio_i.f.generic_hi, gpio_i.f.generic_lo};
    pad_vec.sw_strap  = gpio_i.f.sw_strap;
    pad_vec.tap_strap = {gpio_i.f.tap_strap1, gpio_i.f.tap_strap0};
    pad_vec.uart      = uart_rx_i;
    pad_vec.usb_sense = usb_sense_i;
  end

  // plain flop chain per input bit
  always_ff @(posedge clk_aon) begin
    if (rst_i) begin
      for (int i = 0; i < SYNC_STAGES; i++) begin
        sync_q[i] <= '0;
      end
    end else begin
      sync_q[0] <= pad_vec;
      for (int i = 1; i < SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  assign core_pads_o       = sync_q[SYNC_STAGES-1];
  assign sync_straps_o.sw  = sync_q[SYNC_STAGES-1].sw_strap;
  assign sync_straps_o.tap = sync_q[SYNC_STAGES-1].tap_strap;

  //////////////////////////////////////////////////
  // core to pads
  //////////////////////////////////////////////////

  assign gpio_o       = map_to_gpio(core_out_i);
  assign gpio_en_o    = map_to_gpio(core_oe_i);
  assign uart_tx_o    = core_out_i.uart;
  assign uart_tx_en_o = core_oe_i.uart;

  // straps reach the latch exactly SYNC_STAGES cycles after the pads
  a_straps_match : assert property (
    @(posedge clk_aon) disable iff (rst_i)
    (!$past(rst_i, 1) && !$past(rst_i, SYNC_STAGES)) |->
      (sync_straps_o == $past({pad_vec.sw_strap, pad_vec.tap_strap}, SYNC_STAGES))
  ) else $error("sync straps do not follow the strap pads");

endmodule : pad_map

`default_nettype wire

// File: src/power_seq.sv
//////////////////////////////////////////////////
// power sequence
// fake supply ramp and glitch filtered power ok
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module power_seq (
  input  logic                     clk_aon,
  input  logic                     rst_i,
  output chip_io_pkg::pwr_status_t pwr_status_o
);

  import chip_io_pkg::*;

  logic [RAMP_W-1:0]   ramp_q;
  logic [STABLE_W-1:0] stable_q;
  logic                vcc_supp;
  logic                stable_done;

  //////////////////////////////////////////////////
  // supply ramp
  //////////////////////////////////////////////////

  // counts once per cycle and holds at all ones
  always_ff @(posedge clk_aon) begin
    if (rst_i) begin
      ramp_q <= '0;
    end else if (ramp_q != {RAMP_W{1'b1}}) begin
      ramp_q <= ramp_q + 1'b1;
    end
  end

  // low, high, low, high
  always_comb begin
    if (ramp_q < RAMP_ON1) begin
      vcc_supp = 1'b0;
    end else if (ramp_q < RAMP_OFF) begin
      vcc_supp = 1'b1;
    end else if (ramp_q < RAMP_ON2) begin
      vcc_supp = 1'b0;
    end else begin
      vcc_supp = 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // glitch filter
  //////////////////////////////////////////////////

  assign stable_done = (stable_q == STABLE_W'(POR_STABLE_CYCLES));

  // counts consecutive supply high cycles and clears on any low
  always_ff @(posedge clk_aon) begin
    if (rst_i) begin
      stable_q <= '0;
    end else if (!vcc_supp) begin
      stable_q <= '0;
    end else if (!stable_done) begin
      stable_q <= stable_q + 1'b1;
    end
  end

  // drops together with the supply without an extra cycle of por_ok
  assign pwr_status_o.vcc_supp = vcc_supp;
  assign pwr_status_o.por_ok   = vcc_supp && stable_done;

  // the filter only settles once the supply is up for good
  a_por_needs_supply : assert property (
    @(posedge clk_aon) disable iff (rst_i)
    stable_done |-> vcc_supp
  ) else $error("glitch filter settled while supply is low");

  // a rising por_ok means the supply was already up a full window ago
  a_por_after_window : assert property (
    @(posedge clk_aon) disable iff (rst_i)
    $rose(pwr_status_o.por_ok) |-> $past(vcc_supp, POR_STABLE_CYCLES)
  ) else $error("por_ok rose before the supply was stable");

endmodule : power_seq

`default_nettype wire

// File: src/strap_latch.sv
//////////////////////////////////////////////////
// strap latch
// captures straps once power is good, then lets the core out of reset
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module strap_latch (
  input  logic                 clk_aon,
  input  logic                 rst_i,
  input  logic                 por_ok_i,
  input  chip_io_pkg::straps_t sync_straps_i,
  output chip_io_pkg::straps_t straps_o,
  output logic                 straps_valid_o,
  output logic                 core_rst_o
);

  import chip_io_pkg::*;

  straps_t straps_q;
  logic    valid_q;

  //////////////////////////////////////////////////
  // capture
  //////////////////////////////////////////////////

  // first por_ok cycle takes the straps, losing power re-arms
  always_ff @(posedge clk_aon) begin
    if (rst_i) begin
      straps_q <= '0;
      valid_q  <= 1'b0;
    end else if (!por_ok_i) begin
      valid_q  <= 1'b0;
    end else if (!valid_q) begin
      straps_q <= sync_straps_i;
      valid_q  <= 1'b1;
    end
  end

  assign straps_o       = straps_q;
  assign straps_valid_o = valid_q;

  // core held in reset until the straps are in
  assign core_rst_o     = ~valid_q;

  // straps are frozen for as long as power stays good
  a_straps_frozen : assert property (
    @(posedge clk_aon) disable iff (rst_i)
    (straps_valid_o && por_ok_i) |=> $stable(straps_o)
  ) else $error("straps changed after capture");

endmodule : strap_latch

`default_nettype wire

// File: src/chip_io_shell.sv
//////////////////////////////////////////////////
// chip io shell
// pad mapping, fake power on and strap capture around the core
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module chip_io_shell (
  input  logic                     clk_aon,
  input  logic                     rst_i,

  // gpio pads
  input  chip_io_pkg::gpio_word_u  gpio_i,
  output chip_io_pkg::gpio_word_u  gpio_o,
  output chip_io_pkg::gpio_word_u  gpio_en_o,

  // uart and usb sense pads
  input  logic                     uart_rx_i,
  output logic                     uart_tx_o,
  output logic                     uart_tx_en_o,
  input  logic                     usb_sense_i,

  // core pad vector
  input  chip_io_pkg::mio_pads_t   core_out_i,
  input  chip_io_pkg::mio_pads_t   core_oe_i,
  output chip_io_pkg::mio_pads_t   core_pads_o,

  // power and boot
  output chip_io_pkg::pwr_status_t pwr_status_o,
  output chip_io_pkg::straps_t     straps_o,
  output logic                     straps_valid_o,
  output logic                     core_rst_o
);

  import chip_io_pkg::*;

  straps_t sync_straps;

  //////////////////////////////////////////////////
  // pads
  //////////////////////////////////////////////////

  pad_map u_pad_map (
    .clk_aon       ( clk_aon      ),
    .rst_i         ( rst_i        ),
    .gpio_i        ( gpio_i       ),
    .uart_rx_i     ( uart_rx_i    ),
    .usb_sense_i   ( usb_sense_i  ),
    .core_out_i    ( core_out_i   ),
    .core_oe_i     ( core_oe_i    ),
    .gpio_o        ( gpio_o       ),
    .gpio_en_o     ( gpio_en_o    ),
    .uart_tx_o     ( uart_tx_o    ),
    .uart_tx_en_o  ( uart_tx_en_o ),
    .core_pads_o   ( core_pads_o  ),
    .sync_straps_o ( sync_straps  )
  );

  //////////////////////////////////////////////////
  // power on
  //////////////////////////////////////////////////

  power_seq u_power_seq (
    .clk_aon      ( clk_aon      ),
    .rst_i        ( rst_i        ),
    .pwr_status_o ( pwr_status_o )
  );

  //////////////////////////////////////////////////
  // straps and core reset
  //////////////////////////////////////////////////

  // straps come in through the pad sync, power good from the ramp
  strap_latch u_strap_latch (
    .clk_aon        ( clk_aon             ),
    .rst_i          ( rst_i               ),
    .por_ok_i       ( pwr_status_o.por_ok ),
    .sync_straps_i  ( sync_straps         ),
    .straps_o       ( straps_o            ),
    .straps_valid_o ( straps_valid_o      ),
    .core_rst_o     ( core_rst_o          )
  );

endmodule : chip_io_shell

`default_nettype wire

// File: verification/chip_io_tb.sv
//////////////////////////////////////////////////
// chip io shell testbench
// random pad and core stimulus checked against a cycle model
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module chip_io_tb;

  import chip_io_pkg::*;

  localparam int          CLK_HALF       = 20;
  localparam int          RESET_CYCLES   = 16;
  localparam int          RUN_CYCLES     = 40;
  localparam int          ROUNDS         = 3;
  localparam int          IN_DELAY       = 2;
  localparam int          POR_CYCLE      = 18;
  localparam int          STRAP_SRC      = POR_CYCLE - IN_DELAY;
  localparam int          TIMEOUT_CYCLES = 2 * ROUNDS * (RESET_CYCLES + RUN_CYCLES + 1);
  localparam int          N_TESTS        = 5;
  localparam logic [31:0] SEED           = 32'he59f;

  localparam int T_RESET   = 0;
  localparam int T_POWER   = 1;
  localparam int T_IN_MAP  = 2;
  localparam int T_OUT_MAP = 3;
  localparam int T_STRAP   = 4;

  logic        clk_aon;
  logic        rst_i;
  gpio_word_u  gpio_i;
  logic        uart_rx_i;
  logic        usb_sense_i;
  mio_pads_t   core_out_i;
  mio_pads_t   core_oe_i;
  gpio_word_u  gpio_o;
  gpio_word_u  gpio_en_o;
  logic        uart_tx_o;
  logic        uart_tx_en_o;
  mio_pads_t   core_pads_o;
  pwr_status_t pwr_status_o;
  straps_t     straps_o;
  logic        straps_valid_o;
  logic        core_rst_o;

  // decoded pad inputs of each run cycle for the model
  mio_pads_t pad_hist [RUN_CYCLES];

  int test_checks [N_TESTS];
  int test_errors [N_TESTS];
  int tests_run    = 0;
  int tests_passed = 0;
  int tests_failed = 0;
  int cycle_count  = 0;

  chip_io_shell dut (
    .clk_aon        ( clk_aon        ),
    .rst_i          ( rst_i          ),
    .gpio_i         ( gpio_i         ),
    .gpio_o         ( gpio_o         ),
    .gpio_en_o      ( gpio_en_o      ),
    .uart_rx_i      ( uart_rx_i      ),
    .uart_tx_o      ( uart_tx_o      ),
    .uart_tx_en_o   ( uart_tx_en_o   ),
    .usb_sense_i    ( usb_sense_i    ),
    .core_out_i     ( core_out_i     ),
    .core_oe_i      ( core_oe_i      ),
    .core_pads_o    ( core_pads_o    ),
    .pwr_status_o   ( pwr_status_o   ),
    .straps_o       ( straps_o       ),
    .straps_valid_o ( straps_valid_o ),
    .core_rst_o     ( core_rst_o     )
  );

  initial begin
    clk_aon = 1'b0;
    forever #CLK_HALF clk_aon = ~clk_aon;
  end

  always @(posedge clk_aon) begin
    cycle_count <= cycle_count + 1;
  end

  //////////////////////////////////////////////////
  // model
  //////////////////////////////////////////////////

  // generic at pad bits 13:0, sw straps at 24:22 and tap straps at 27 and 30
  function automatic mio_pads_t decode_pads(input gpio_word_u word, input logic rx,
                                            input logic sense);
    mio_pads_t p;
    p.generic   = word.raw[13:0];
    p.sw_strap  = word.raw[24:22];
    p.tap_strap = {word.raw[30], word.raw[27]};
    p.uart      = rx;
    p.usb_sense = sense;
    return p;
  endfunction

  function automatic gpio_word_u encode_word(input mio_pads_t p);
    gpio_word_u w;
    w.raw        = '0;
    w.raw[13:0]  = p.generic;
    w.raw[24:22] = p.sw_strap;
    w.raw[27]    = p.tap_strap[0];
    w.raw[30]    = p.tap_strap[1];
    return w;
  endfunction

  // ramp count equals the cycle index until it saturates
  function automatic logic supply_at(input int pc);
    int ramp;
    ramp = (pc > (2 ** RAMP_W - 1)) ? (2 ** RAMP_W - 1) : pc;
    return ((ramp >= int'(RAMP_ON1)) && (ramp < int'(RAMP_OFF))) || (ramp >= int'(RAMP_ON2));
  endfunction

  function automatic string test_name(input int id);
    case (id)
      T_RESET:   return "reset_state";
      T_POWER:   return "power_sequence";
      T_IN_MAP:  return "input_mapping";
      T_OUT_MAP: return "output_mapping";
      default:   return "strap_capture";
    endcase
  endfunction

  //////////////////////////////////////////////////
  // stimulus and checks
  //////////////////////////////////////////////////

  task automatic compare(input int id, input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
    test_checks[id]++;
    assert (actual === expected) else begin
      $display("ERROR %s %s: expected %h actual %h", test_name(id), what, expected, actual);
      test_errors[id]++;
    end
  endtask

  task automatic drive_random();
    logic [31:0] r_out;
    logic [31:0] r_oe;
    logic [31:0] r_bits;
    r_out        = $urandom;
    r_oe         = $urandom;
    r_bits       = $urandom;
    gpio_i.raw  <= $urandom;
    uart_rx_i   <= r_bits[0];
    usb_sense_i <= r_bits[1];
    core_out_i  <= r_out[$bits(mio_pads_t)-1:0];
    core_oe_i   <= r_oe[$bits(mio_pads_t)-1:0];
  endtask

  task automatic check_reset_state();
    compare(T_RESET, "core_rst_o", 32'd1, 32'(core_rst_o));
    compare(T_RESET, "straps_valid_o", 32'd0, 32'(straps_valid_o));
    compare(T_RESET, "straps_o", 32'd0, 32'(straps_o));
    compare(T_RESET, "pwr_status_o", 32'd0, 32'(pwr_status_o));
    compare(T_RESET, "core_pads_o", 32'd0, 32'(core_pads_o));
  endtask

  task automatic check_run_cycle(input int pc);
    pwr_status_t exp_pwr;
    mio_pads_t   exp_pads;
    straps_t     exp_straps;
    gpio_word_u  exp_out;
    gpio_word_u  exp_oe;
    pad_hist[pc] = decode_pads(gpio_i, uart_rx_i, usb_sense_i);

    exp_pwr.vcc_supp = supply_at(pc);
    exp_pwr.por_ok   = (pc >= POR_CYCLE);
    compare(T_POWER, "pwr_status_o", 32'(exp_pwr), 32'(pwr_status_o));

    // two flop sync on every pad input
    exp_pads = (pc >= IN_DELAY) ? pad_hist[pc-IN_DELAY] : '0;
    compare(T_IN_MAP, "core_pads_o", 32'(exp_pads), 32'(core_pads_o));

    // combinational in the same cycle as the core drives it
    exp_out = encode_word(core_out_i);
    exp_oe  = encode_word(core_oe_i);
    compare(T_OUT_MAP, "gpio_o", exp_out.raw, gpio_o.raw);
    compare(T_OUT_MAP, "gpio_en_o", exp_oe.raw, gpio_en_o.raw);
    compare(T_OUT_MAP, "uart_tx_o", 32'(core_out_i.uart), 32'(uart_tx_o));
    compare(T_OUT_MAP, "uart_tx_en_o", 32'(core_oe_i.uart), 32'(uart_tx_en_o));

    // captured at the first por_ok cycle and visible one cycle later
    if (pc > POR_CYCLE) begin
      exp_straps.sw  = pad_hist[STRAP_SRC].sw_strap;
      exp_straps.tap = pad_hist[STRAP_SRC].tap_strap;
      compare(T_STRAP, "straps_valid_o", 32'd1, 32'(straps_valid_o));
      compare(T_STRAP, "core_rst_o", 32'd0, 32'(core_rst_o));
    end else begin
      exp_straps = '0;
      compare(T_STRAP, "straps_valid_o", 32'd0, 32'(straps_valid_o));
      compare(T_STRAP, "core_rst_o", 32'd1, 32'(core_rst_o));
    end
    compare(T_STRAP, "straps_o", 32'(exp_straps), 32'(straps_o));
  endtask

  task automatic report_round(input int round);
    for (int t = 0; t < N_TESTS; t++) begin
      tests_run++;
      if (test_errors[t] == 0) begin
        tests_passed++;
        $display("round %0d %s: PASS, %0d checks", round, test_name(t), test_checks[t]);
      end else begin
        tests_failed++;
        $display("round %0d %s: FAIL, %0d of %0d checks wrong", round, test_name(t),
                 test_errors[t], test_checks[t]);
      end
      test_checks[t] = 0;
      test_errors[t] = 0;
    end
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    rst_i       = 1'b1;
    gpio_i.raw  = '0;
    uart_rx_i   = 1'b0;
    usb_sense_i = 1'b0;
    core_out_i  = '0;
    core_oe_i   = '0;
    for (int t = 0; t < N_TESTS; t++) begin
      test_checks[t] = 0;
      test_errors[t] = 0;
    end
    void'($urandom(SEED));

    for (int round = 0; round < ROUNDS; round++) begin
      @(posedge clk_aon);
      rst_i <= 1'b1;
      drive_random();
      // straps keep changing during reset too
      for (int i = 1; i < RESET_CYCLES; i++) begin
        @(posedge clk_aon);
        drive_random();
        @(negedge clk_aon);
        check_reset_state();
      end
      for (int pc = 0; pc < RUN_CYCLES; pc++) begin
        @(posedge clk_aon);
        if (pc == 0) begin
          rst_i <= 1'b0;
        end
        drive_random();
        @(negedge clk_aon);
        if (pc == 0) begin
          check_reset_state();
        end
        check_run_cycle(pc);
      end
      report_round(round);
    end

    $display("%0d tests run, %0d passed, %0d failed", tests_run, tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin
    while (cycle_count <= TIMEOUT_CYCLES) begin
      @(posedge clk_aon);
    end
    $display("timeout: the run was still going after %0d clock cycles", TIMEOUT_CYCLES);
    $display("Test failures found");
    $finish;
  end

endmodule : chip_io_tb

`default_nettype wire

// File: chip_io_shell.f
src/chip_io_pkg.sv
src/pad_map.sv
src/power_seq.sv
src/strap_latch.sv
src/chip_io_shell.sv
verification/chip_io_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the chip_io_shell testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

BUILD_DIR=build
LOG_FILE=sim.log

rm -rf "$BUILD_DIR"

verilator --binary --timing --assert \
  --top-module chip_io_tb \
  -Mdir "$BUILD_DIR" \
  -o chip_io_sim \
  -f chip_io_shell.f

"./$BUILD_DIR/chip_io_sim" | tee "$LOG_FILE"

if grep -q "Test failures found" "$LOG_FILE"; then
  echo "simulation failed, see $LOG_FILE"
  exit 1
fi

echo "simulation passed"
